// ==== tb.f ====
+incdir+hw
hw/sprite_pkg.sv
hw/sprite_regs.sv
hw/sprite_unit.sv
hw/sprite_overlay.sv
hw/video_timing.sv
hw/sprite_top.sv
tb/sprite_tb.sv

// ==== Makefile ====
# Verilator build and run of the sprite overlay testbench

VERILATOR ?= verilator
TOP       ?= sprite_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= RESULT: PASS

SOURCES := $(wildcard hw/*.sv hw/*.svh tb/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it, log to $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_TEXT"

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/sprite_tb.sv ====
/*
 Sprite overlay engine testbench.
 Programs the sprites over APB from LFSR stimulus, checks
 register read-back and slave errors, and compares every
 pixel of whole frames with a model of registers and bitmaps.
*/

`default_nettype none

`include "sprite_consts.svh"

module sprite_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import sprite_pkg::*;

	localparam int CLOCK_PERIOD = 8;
	localparam int APB_TIMEOUT = 16;
	localparam int FRAME_PIXELS = `H_TOTAL * `V_TOTAL;
	localparam int FRAME_TIMEOUT = FRAME_PIXELS + 16;

	logic clock;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	color_t pixel;
	logic pixel_mask;
	coord_t ras_x;
	coord_t ras_y;
	logic hblank;
	logic vblank;

	logic [31:0] lfsr = 32'hc04e;
	int error_count = 0;
	int test_count = 0;
	int failed_tests = 0;

	// model of the programmed sprite state
	coord_t m_pos_x [`SPRITE_COUNT];
	coord_t m_pos_y [`SPRITE_COUNT];
	color_t m_color [`SPRITE_COUNT];
	logic m_enable [`SPRITE_COUNT];
	row_t m_bitmap [`SPRITE_COUNT][`SPRITE_SIZE];

	sprite_top dut_i (
		.i_clock(clock),
		.i_arst_n(arst_n),
		.i_psel(psel),
		.i_penable(penable),
		.i_pwrite(pwrite),
		.i_paddr(paddr),
		.i_pwdata(pwdata),
		.o_prdata(prdata),
		.o_pready(pready),
		.o_pslverr(pslverr),
		.o_pixel(pixel),
		.o_pixel_mask(pixel_mask),
		.o_x(ras_x),
		.o_y(ras_y),
		.o_hblank(hblank),
		.o_vblank(vblank)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// ########################################
	// stimulus helpers
	// ########################################

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic apb_addr_t sprite_addr(input int sprite, input int offset);
		return apb_addr_t'(sprite * 32 + offset);
	endfunction

	task automatic report_timeout(input string reason);
		error_count++;
		$display("timeout at %0d ns: %s", $time, reason);
	endtask

	// one APB transfer, setup phase then access phase
	task automatic apb_transfer(input apb_addr_t addr, input logic write,
			input apb_data_t wdata, output apb_data_t rdata, output logic err);
		int waited;
		@(negedge clock);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clock);
		check_error(pready, 1'b0, "pready in setup phase");
		@(negedge clock);
		penable = 1'b1;
		waited = 0;
		@(posedge clock);
		while (!pready && waited < APB_TIMEOUT) begin
			waited++;
			@(posedge clock);
		end
		if (!pready)
			report_timeout($sformatf("no pready for address %02h", addr));
		rdata = prdata;
		err = pslverr;
		@(negedge clock);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// ########################################
	// reference model
	// ########################################

	function automatic logic expect_slverr(input apb_addr_t addr);
		return (addr[7:6] != 2'b00) || (addr[4:0] >= 5'd4 && addr[4:0] < 5'd16);
	endfunction

	function automatic apb_data_t expect_read(input apb_addr_t addr);
		apb_data_t value;
		value = '0;
		if (addr[7:6] == 2'b00) begin
			case (addr[4:0])
				5'd0: value = apb_data_t'(m_pos_x[addr[5]]);
				5'd1: value = apb_data_t'(m_pos_y[addr[5]]);
				5'd2: value = apb_data_t'(m_color[addr[5]]);
				5'd3: value = apb_data_t'(m_enable[addr[5]]);
				default: value = '0;
			endcase
		end
		return value;
	endfunction

	task automatic update_model(input apb_addr_t addr, input apb_data_t data);
		if (addr[7:6] == 2'b00) begin
			case (addr[4:0])
				5'd0: m_pos_x[addr[5]] = coord_t'(data);
				5'd1: m_pos_y[addr[5]] = coord_t'(data);
				5'd2: m_color[addr[5]] = color_t'(data);
				5'd3: m_enable[addr[5]] = data[0];
				default: begin
					if (addr[4])
						m_bitmap[addr[5]][addr[3:0]] = row_t'(data);
				end
			endcase
		end
	endtask

	// pixel rule, first hitting sprite in index order wins
	function automatic void expected_pixel(input coord_t x, input coord_t y,
			output color_t color, output logic mask);
		int dx;
		int dy;
		color = '0;
		mask = 1'b0;
		if (x < `H_ACTIVE && y < `V_ACTIVE) begin
			for (int s = 0; s < `SPRITE_COUNT; s++) begin
				dx = int'(x) - int'(m_pos_x[s]);
				dy = int'(y) - int'(m_pos_y[s]);
				if (!mask && m_enable[s] && dx >= 0 && dx < `SPRITE_SIZE
						&& dy >= 0 && dy < `SPRITE_SIZE) begin
					if (m_bitmap[s][dy][dx]) begin
						color = m_color[s];
						mask = 1'b1;
					end
				end
			end
		end
	endfunction

	// ########################################
	// compare tasks
	// ########################################

	task automatic check_data(input apb_data_t actual, input apb_data_t expected,
			input string what);
		if (actual !== expected) begin
			error_count++;
			$display("error at %0d ns: %s gave %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_pixel(input color_t actual, input logic actual_mask,
			input color_t expected, input logic expected_mask, input string what);
		if (actual !== expected || actual_mask !== expected_mask) begin
			error_count++;
			$display("error at %0d ns: %s gave colour %h mask %b, expected %h mask %b",
				$time, what, actual, actual_mask, expected, expected_mask);
		end
	endtask

	task automatic check_error(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			error_count++;
			$display("error at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic check_coord(input coord_t x, input coord_t y, input coord_t exp_x,
			input coord_t exp_y);
		if (x !== exp_x || y !== exp_y) begin
			error_count++;
			$display("error at %0d ns: raster at %0d,%0d, expected %0d,%0d",
				$time, x, y, exp_x, exp_y);
		end
	endtask

	// ########################################
	// test steps
	// ########################################

	task automatic write_checked(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rdata;
		logic err;
		apb_transfer(addr, 1'b1, data, rdata, err);
		check_error(err, expect_slverr(addr), $sformatf("pslverr on write %02h", addr));
		update_model(addr, data);
	endtask

	task automatic read_checked(input apb_addr_t addr);
		apb_data_t rdata;
		logic err;
		apb_transfer(addr, 1'b0, '0, rdata, err);
		check_data(rdata, expect_read(addr), $sformatf("read %02h", addr));
		check_error(err, expect_slverr(addr), $sformatf("pslverr on read %02h", addr));
	endtask

	task automatic program_sprite(input int sprite, input coord_t x, input coord_t y);
		write_checked(sprite_addr(sprite, 0), apb_data_t'(x));
		write_checked(sprite_addr(sprite, 1), apb_data_t'(y));
		write_checked(sprite_addr(sprite, 2), random_bits(8));
		for (int r = 0; r < `SPRITE_SIZE; r++)
			write_checked(sprite_addr(sprite, 16 + r), random_bits(16));
	endtask

	// compare one whole frame, starting at pixel 0,0
	task automatic scan_frame();
		int waited;
		int exp_x;
		int exp_y;
		color_t exp_color;
		logic exp_mask;
		waited = 0;
		@(negedge clock);
		while (!(ras_x == 0 && ras_y == 0) && waited < FRAME_TIMEOUT) begin
			waited++;
			@(negedge clock);
		end
		if (ras_x != 0 || ras_y != 0) begin
			report_timeout("raster never returned to pixel 0,0");
		end
		else begin
			exp_x = 0;
			exp_y = 0;
			for (int n = 0; n < FRAME_PIXELS; n++) begin
				check_coord(ras_x, ras_y, coord_t'(exp_x), coord_t'(exp_y));
				expected_pixel(ras_x, ras_y, exp_color, exp_mask);
				check_pixel(pixel, pixel_mask, exp_color, exp_mask,
					$sformatf("pixel %0d,%0d", ras_x, ras_y));
				check_error(hblank, ras_x >= `H_ACTIVE, "hblank");
				check_error(vblank, ras_y >= `V_ACTIVE, "vblank");
				exp_x = (exp_x + 1) % `H_TOTAL;
				if (exp_x == 0)
					exp_y++;
				@(negedge clock);
			end
		end
	endtask

	task automatic wait_for_line(input int line);
		int waited;
		waited = 0;
		@(negedge clock);
		while (ras_y != line && waited < FRAME_TIMEOUT) begin
			waited++;
			@(negedge clock);
		end
		if (ras_y != line)
			report_timeout($sformatf("raster never reached line %0d", line));
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
		end
		else begin
			failed_tests++;
			$display("test %s: %0d errors", name, error_count - errors_before);
		end
	endtask

	// ########################################
	// test sequence
	// ########################################

	initial begin
		apb_addr_t addr;
		int errors_before;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		arst_n = 1'b0;
		for (int s = 0; s < `SPRITE_COUNT; s++) begin
			m_pos_x[s] = '0;
			m_pos_y[s] = '0;
			m_color[s] = '0;
			m_enable[s] = 1'b0;
			for (int r = 0; r < `SPRITE_SIZE; r++)
				m_bitmap[s][r] = '0;
		end
		repeat (2) @(negedge clock);
		arst_n = 1'b1;

		errors_before = error_count;
		for (int s = 0; s < `SPRITE_COUNT; s++)
			for (int off = 0; off < 4; off++)
				read_checked(sprite_addr(s, off));
		scan_frame();
		finish_test("reset state", errors_before);

		errors_before = error_count;
		for (int s = 0; s < `SPRITE_COUNT; s++) begin
			for (int off = 0; off < 4; off++) begin
				write_checked(sprite_addr(s, off), random_bits(32));
				read_checked(sprite_addr(s, off));
			end
			for (int r = 0; r < `SPRITE_SIZE; r++) begin
				write_checked(sprite_addr(s, 16 + r), random_bits(32));
				read_checked(sprite_addr(s, 16 + r));
			end
		end
		finish_test("register read-back", errors_before);

		// offset holes and upper pages in turn
		errors_before = error_count;
		for (int n = 0; n < 16; n++) begin
			if (n % 2 == 0) begin
				addr = sprite_addr(int'(random_bits(1)), 4 + int'(random_bits(4) % 12));
			end
			else begin
				addr = apb_addr_t'(random_bits(8));
				if (addr[7:6] == 2'b00)
					addr[7:6] = 2'b11;
			end
			write_checked(addr, random_bits(32));
			read_checked(addr);
			read_checked({2'b00, addr[5], 3'b000, addr[1:0]});
		end
		finish_test("slave errors", errors_before);

		// sprite 0 alone, inside the frame, then across the corner
		errors_before = error_count;
		write_checked(sprite_addr(1, 3), 32'd0);
		program_sprite(0, coord_t'(random_bits(6)), coord_t'(random_bits(5)));
		write_checked(sprite_addr(0, 3), 32'd1);
		scan_frame();
		program_sprite(0, coord_t'(`H_ACTIVE - 8 + random_bits(3)),
			coord_t'(`V_ACTIVE - 8 + random_bits(3)));
		scan_frame();
		finish_test("single sprite frames", errors_before);

		errors_before = error_count;
		program_sprite(0, coord_t'(8 + random_bits(5)), coord_t'(8 + random_bits(4)));
		program_sprite(1, m_pos_x[0] + coord_t'(1 + random_bits(3)),
			m_pos_y[0] + coord_t'(1 + random_bits(3)));
		// distinct colours so the winner shows
		write_checked(sprite_addr(1, 2), {24'h0, ~m_color[0]});
		write_checked(sprite_addr(1, 3), 32'd1);
		scan_frame();
		finish_test("overlap priority", errors_before);

		errors_before = error_count;
		wait_for_line(`V_ACTIVE / 2);
		write_checked(sprite_addr(0, 3), 32'd0);
		scan_frame();
		finish_test("disable mid-frame", errors_before);

		$display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/sprite_top.sv ====
/*
 Sprite overlay engine top.
 APB register bank, raster timing and the sprite overlay.
 Puts out an overlay pixel and mask with the raster position.
*/

`default_nettype none

`include "sprite_consts.svh"

module sprite_top (
	input wire i_clock,
	input wire i_arst_n,

	input wire i_psel,
	input wire i_penable,
	input wire i_pwrite,
	input wire sprite_pkg::apb_addr_t i_paddr,
	input wire sprite_pkg::apb_data_t i_pwdata,
	output sprite_pkg::apb_data_t o_prdata,
	output logic o_pready,
	output logic o_pslverr,

	output sprite_pkg::color_t o_pixel,
	output logic o_pixel_mask,
	output sprite_pkg::coord_t o_x,
	output sprite_pkg::coord_t o_y,
	output logic o_hblank,
	output logic o_vblank
);

	import sprite_pkg::*;

	coord_t pos_x [`SPRITE_COUNT];
	coord_t pos_y [`SPRITE_COUNT];
	color_t color [`SPRITE_COUNT];
	logic [`SPRITE_COUNT-1:0] enable;
	logic [`SPRITE_COUNT-1:0] row_we;
	row_index_t row_index;
	row_t row_data;

	// raster straight from the counters
	coord_t ras_x;
	coord_t ras_y;
	logic ras_hblank;
	logic ras_vblank;

	sprite_regs regs_i (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_pwrite(i_pwrite),
		.i_paddr(i_paddr),
		.i_pwdata(i_pwdata),
		.o_prdata(o_prdata),
		.o_pready(o_pready),
		.o_pslverr(o_pslverr),
		.o_pos_x(pos_x),
		.o_pos_y(pos_y),
		.o_color(color),
		.o_enable(enable),
		.o_row_we(row_we),
		.o_row_index(row_index),
		.o_row_data(row_data)
	);

	video_timing timing_i (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.o_x(ras_x),
		.o_y(ras_y),
		.o_hblank(ras_hblank),
		.o_vblank(ras_vblank)
	);

	sprite_overlay overlay_i (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_pos_x(pos_x),
		.i_pos_y(pos_y),
		.i_color(color),
		.i_enable(enable),
		.i_row_we(row_we),
		.i_row_index(row_index),
		.i_row_data(row_data),
		.i_x(ras_x),
		.i_y(ras_y),
		.i_hblank(ras_hblank),
		.i_vblank(ras_vblank),
		.o_x(o_x),
		.o_y(o_y),
		.o_hblank(o_hblank),
		.o_vblank(o_vblank),
		.o_pixel(o_pixel),
		.o_pixel_mask(o_pixel_mask)
	);

endmodule

`default_nettype wire

// ==== hw/video_timing.sv ====
/*
 Video timing generator.
 Free-running horizontal and vertical counters over the test
 raster, with blanking decoded from the counter values.
*/

`default_nettype none

`include "sprite_consts.svh"

module video_timing (
	input wire i_clock,
	input wire i_arst_n,

	output sprite_pkg::coord_t o_x,
	output sprite_pkg::coord_t o_y,
	output logic o_hblank,
	output logic o_vblank
);

	import sprite_pkg::*;

	localparam coord_t X_LAST = coord_t'(`H_TOTAL - 1);
	localparam coord_t Y_LAST = coord_t'(`V_TOTAL - 1);
	localparam coord_t X_ACTIVE = coord_t'(`H_ACTIVE);
	localparam coord_t Y_ACTIVE = coord_t'(`V_ACTIVE);

	coord_t x_q;
	coord_t y_q;
	logic line_end;

	assign line_end = (x_q == X_LAST);

	// ########################################
	// counters
	// ########################################

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			x_q <= '0;
		end
		else if (line_end) begin
			x_q <= '0;
		end
		else begin
			x_q <= x_q + 1'b1;
		end
	end

	// y steps once per line
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			y_q <= '0;
		end
		else if (line_end) begin
			if (y_q == Y_LAST)
				y_q <= '0;
			else
				y_q <= y_q + 1'b1;
		end
	end

	assign o_x = x_q;
	assign o_y = y_q;
	assign o_hblank = (x_q >= X_ACTIVE);
	assign o_vblank = (y_q >= Y_ACTIVE);

endmodule

`default_nettype wire

// ==== hw/sprite_overlay.sv ====
/*
 Sprite overlay.
 Feeds the raster to every sprite unit and merges their
 outputs, lowest sprite index on top. The raster position is
 delayed one cycle to stay aligned with the unit outputs.
*/

`default_nettype none

`include "sprite_consts.svh"

module sprite_overlay (
	input wire i_clock,
	input wire i_arst_n,

	input wire sprite_pkg::coord_t i_pos_x [`SPRITE_COUNT],
	input wire sprite_pkg::coord_t i_pos_y [`SPRITE_COUNT],
	input wire sprite_pkg::color_t i_color [`SPRITE_COUNT],
	input wire [`SPRITE_COUNT-1:0] i_enable,

	input wire [`SPRITE_COUNT-1:0] i_row_we,
	input wire sprite_pkg::row_index_t i_row_index,
	input wire sprite_pkg::row_t i_row_data,

	input wire sprite_pkg::coord_t i_x,
	input wire sprite_pkg::coord_t i_y,
	input wire i_hblank,
	input wire i_vblank,

	output sprite_pkg::coord_t o_x,
	output sprite_pkg::coord_t o_y,
	output logic o_hblank,
	output logic o_vblank,
	output sprite_pkg::color_t o_pixel,
	output logic o_pixel_mask
);

	import sprite_pkg::*;

	color_t unit_color [`SPRITE_COUNT];
	logic [`SPRITE_COUNT-1:0] unit_mask;

	for (genvar g = 0; g < `SPRITE_COUNT; g++) begin : g_unit
		sprite_unit unit_i (
			.i_clock(i_clock),
			.i_arst_n(i_arst_n),
			.i_pos_x(i_pos_x[g]),
			.i_pos_y(i_pos_y[g]),
			.i_color(i_color[g]),
			.i_enable(i_enable[g]),
			.i_row_we(i_row_we[g]),
			.i_row_index(i_row_index),
			.i_row_data(i_row_data),
			.i_x(i_x),
			.i_y(i_y),
			.i_hblank(i_hblank),
			.i_vblank(i_vblank),
			.o_color(unit_color[g]),
			.o_mask(unit_mask[g])
		);
	end

	// walk down so the lowest hitting index is written last
	always_comb begin
		o_pixel = '0;
		for (int i = `SPRITE_COUNT - 1; i >= 0; i--) begin
			if (unit_mask[i])
				o_pixel = unit_color[i];
		end
	end

	assign o_pixel_mask = |unit_mask;

	// raster delay matching the unit registers
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_x <= '0;
			o_y <= '0;
			o_hblank <= 1'b0;
			o_vblank <= 1'b0;
		end
		else begin
			o_x <= i_x;
			o_y <= i_y;
			o_hblank <= i_hblank;
			o_vblank <= i_vblank;
		end
	end

endmodule

`default_nettype wire

// ==== hw/sprite_unit.sv ====
/*
 Sprite unit.
 Holds one 16x16 one-bit bitmap and tests each raster pixel
 against it. Colour and mask are registered, so the result
 trails the raster position by one cycle.
*/

`default_nettype none

`include "sprite_consts.svh"

module sprite_unit (
	input wire i_clock,
	input wire i_arst_n,

	input wire sprite_pkg::coord_t i_pos_x,
	input wire sprite_pkg::coord_t i_pos_y,
	input wire sprite_pkg::color_t i_color,
	input wire i_enable,

	input wire i_row_we,
	input wire sprite_pkg::row_index_t i_row_index,
	input wire sprite_pkg::row_t i_row_data,

	input wire sprite_pkg::coord_t i_x,
	input wire sprite_pkg::coord_t i_y,
	input wire i_hblank,
	input wire i_vblank,

	output sprite_pkg::color_t o_color,
	output logic o_mask
);

	import sprite_pkg::*;

	// one extra bit so a pixel left of or above the origin goes negative
	localparam logic [`COORD_WIDTH:0] SIZE_LIMIT = `SPRITE_SIZE;

	row_t bitmap [`SPRITE_SIZE];
	logic [`COORD_WIDTH:0] dx;
	logic [`COORD_WIDTH:0] dy;
	logic in_box;
	logic pix_set;
	logic hit;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < `SPRITE_SIZE; i++)
				bitmap[i] <= '0;
		end
		else if (i_row_we) begin
			bitmap[i_row_index] <= i_row_data;
		end
	end

	// ########################################
	// hit test
	// ########################################

	// offset from the sprite origin
	assign dx = {1'b0, i_x} - {1'b0, i_pos_x};
	assign dy = {1'b0, i_y} - {1'b0, i_pos_y};

	// negative offsets wrap high and fail the compare
	assign in_box = (dx < SIZE_LIMIT) && (dy < SIZE_LIMIT);
	assign pix_set = bitmap[row_index_t'(dy)][row_index_t'(dx)];

	assign hit = i_enable && in_box && pix_set && !i_hblank && !i_vblank;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			o_mask <= 1'b0;
		else
			o_mask <= hit;
	end

	always_ff @(posedge i_clock) begin
		o_color <= i_color;
	end

endmodule

`default_nettype wire

// ==== hw/sprite_regs.sv ====
/*
 Sprite register bank.
 APB slave with no wait states. Holds position, colour and
 enable for every sprite and forwards bitmap row writes as
 single-cycle strobes to the sprite units.
*/

`default_nettype none

`include "sprite_consts.svh"

module sprite_regs (
	input wire i_clock,
	input wire i_arst_n,

	input wire i_psel,
	input wire i_penable,
	input wire i_pwrite,
	input wire sprite_pkg::apb_addr_t i_paddr,
	input wire sprite_pkg::apb_data_t i_pwdata,
	output sprite_pkg::apb_data_t o_prdata,
	output logic o_pready,
	output logic o_pslverr,

	output sprite_pkg::coord_t o_pos_x [`SPRITE_COUNT],
	output sprite_pkg::coord_t o_pos_y [`SPRITE_COUNT],
	output sprite_pkg::color_t o_color [`SPRITE_COUNT],
	output logic [`SPRITE_COUNT-1:0] o_enable,

	output logic [`SPRITE_COUNT-1:0] o_row_we,
	output sprite_pkg::row_index_t o_row_index,
	output sprite_pkg::row_t o_row_data
);

	import sprite_pkg::*;

	logic access;
	logic page_ok;
	logic is_ctrl;
	logic is_row;
	logic ctrl_we;
	sprite_index_t sel;
	logic [4:0] offset;

	// ########################################
	// address decode
	// ########################################

	assign access = i_psel && i_penable;
	// bit 5 picks the sprite, bits 4:0 the offset
	assign sel = i_paddr[5];
	assign offset = i_paddr[4:0];
	assign page_ok = (i_paddr[7:6] == 2'b00);

	// offsets 0..3 control, 16..31 bitmap rows, rest unmapped
	assign is_ctrl = page_ok && (offset[4:2] == 3'b000);
	assign is_row = page_ok && offset[4];

	assign o_pready = access;
	assign o_pslverr = access && !(is_ctrl || is_row);
	assign ctrl_we = access && i_pwrite && is_ctrl;

	// ########################################
	// control registers
	// ########################################

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < `SPRITE_COUNT; i++) begin
				o_pos_x[i] <= '0;
				o_pos_y[i] <= '0;
				o_color[i] <= '0;
			end
			o_enable <= '0;
		end
		else if (ctrl_we) begin
			case (offset[1:0])
				2'd0: o_pos_x[sel] <= coord_t'(i_pwdata);
				2'd1: o_pos_y[sel] <= coord_t'(i_pwdata);
				2'd2: o_color[sel] <= color_t'(i_pwdata);
				default: o_enable[sel] <= i_pwdata[0];
			endcase
		end
	end

	// read data, bitmap rows and holes read zero
	always_comb begin
		o_prdata = '0;
		if (access && !i_pwrite && is_ctrl) begin
			case (offset[1:0])
				2'd0: o_prdata = apb_data_t'(o_pos_x[sel]);
				2'd1: o_prdata = apb_data_t'(o_pos_y[sel]);
				2'd2: o_prdata = apb_data_t'(o_color[sel]);
				default: o_prdata = apb_data_t'(o_enable[sel]);
			endcase
		end
	end

	// ########################################
	// bitmap row strobes
	// ########################################

	// unit stores the row on the edge ending the access
	always_comb begin
		o_row_we = '0;
		if (access && i_pwrite && is_row)
			o_row_we[sel] = 1'b1;
	end

	assign o_row_index = offset[3:0];
	assign o_row_data = row_t'(i_pwdata);

endmodule

`default_nettype wire

// ==== hw/sprite_pkg.sv ====
/*
 Sprite overlay package.
 Vector types shared by the register bank, the timing
 generator and the sprite units.
*/

`default_nettype none

`include "sprite_consts.svh"

package sprite_pkg;

	// pixel coordinate or sprite position
	typedef logic [`COORD_WIDTH-1:0] coord_t;
	// overlay colour index
	typedef logic [7:0] color_t;

	// one bitmap row, bit n is column n
	typedef logic [`SPRITE_SIZE-1:0] row_t;
	typedef logic [$clog2(`SPRITE_SIZE)-1:0] row_index_t;
	typedef logic [$clog2(`SPRITE_COUNT)-1:0] sprite_index_t;

	// APB word address and data
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

endpackage

`default_nettype wire

// ==== hw/sprite_consts.svh ====
/*
 Sprite overlay constants.
 Sprite count and size, pixel coordinate width and the
 dimensions of the reduced test raster.
*/

`ifndef SPRITE_CONSTS_SVH
`define SPRITE_CONSTS_SVH

// ########################################
// sprites
// ########################################

// number of sprite units, lower index wins
`define SPRITE_COUNT 2
// bitmap edge length in pixels
`define SPRITE_SIZE 16

// ########################################
// raster
// ########################################

`define COORD_WIDTH 11

// visible and total pixels per line
`define H_ACTIVE 64
`define H_TOTAL 80
// visible and total lines per frame
`define V_ACTIVE 48
`define V_TOTAL 52

`endif
